// ==== include/glay_settings.svh ====
// Global sizing for the graph kernel compute unit
// Included by the package and by any module that sizes ports from these values
// Change the run timer length here to stretch or shorten a run

`ifndef GLAY_SETTINGS_SVH
`define GLAY_SETTINGS_SVH

// Memory address and write data widths
`define GLAY_ADDR_W 32
`define GLAY_DATA_W 32

// Request queue sizing, depth must stay a power of two
`define GLAY_FIFO_DEPTH 4
`define GLAY_FIFO_PTR_W 2

// Minimum run length in cycles before done may be raised
`define GLAY_RUN_CYCLES 40

// Number of requesters merged onto the memory port
`define GLAY_NUM_REQ 2

`endif

// ==== logic/glay_pkg.sv ====
// Shared types for the graph kernel compute unit
// Compile first; modules refer to items here with the glay_pkg:: prefix

`include "glay_settings.svh"

package glay_pkg;

  // --------------------
  // Control states
  // --------------------
  typedef enum logic [1:0] {
    CTRL_IDLE  = 2'd0,
    CTRL_SETUP = 2'd1,
    CTRL_RUN   = 2'd2,
    CTRL_DONE  = 2'd3
  } ctrl_state_t;

  // --------------------
  // Request opcodes
  // --------------------
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } req_op_t;

  // Memory address, rebased onto the graph base
  typedef logic [`GLAY_ADDR_W-1:0] addr_t;

  // Write data carried with each request
  typedef logic [`GLAY_DATA_W-1:0] data_t;

endpackage

// ==== logic/glay_request_fifo.sv ====
// Synchronous request queue for rebased memory requests
// Push and pop may land in the same cycle; head fields read the entry
// at the read pointer with no output register

`include "glay_settings.svh"

module glay_request_fifo (
  input  logic              ap_clk,
  input  logic              m_axi_areset,
  input  logic              push,
  input  glay_pkg::req_op_t push_op,
  input  glay_pkg::addr_t   push_addr,
  input  glay_pkg::data_t   push_wdata,
  output logic              full,
  output logic              empty,
  output glay_pkg::req_op_t head_op,
  output glay_pkg::addr_t   head_addr,
  output glay_pkg::data_t   head_wdata,
  input  logic              pop
);

  // Entry storage
  glay_pkg::req_op_t entry_op    [0:`GLAY_FIFO_DEPTH-1];
  glay_pkg::addr_t   entry_addr  [0:`GLAY_FIFO_DEPTH-1];
  glay_pkg::data_t   entry_wdata [0:`GLAY_FIFO_DEPTH-1];

  logic [`GLAY_FIFO_PTR_W-1:0] wr_ptr;
  logic [`GLAY_FIFO_PTR_W-1:0] rd_ptr;
  logic [`GLAY_FIFO_PTR_W:0]   count;
  logic                        do_push;
  logic                        do_pop;

  // Guard against overflow and underflow
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == (`GLAY_FIFO_PTR_W+1)'(`GLAY_FIFO_DEPTH));
  assign empty = (count == '0);

  // --------------------
  // Pointers and occupancy
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Both at once leaves the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Write side
  always_ff @(posedge ap_clk) begin
    if (do_push) begin
      entry_op[wr_ptr]    <= push_op;
      entry_addr[wr_ptr]  <= push_addr;
      entry_wdata[wr_ptr] <= push_wdata;
    end
  end

  // Head of queue
  assign head_op    = entry_op[rd_ptr];
  assign head_addr  = entry_addr[rd_ptr];
  assign head_wdata = entry_wdata[rd_ptr];

endmodule

// ==== logic/glay_request_arbiter.sv ====
// Execute stage: merges the requesters onto one memory port
// Round-robin grant, address rebase onto graph_base, then the request queue
// The memory side sees the queue head directly

`include "glay_settings.svh"

module glay_request_arbiter (
  input  logic                 ap_clk,
  input  logic                 m_axi_areset,
  input  logic                 running,
  input  glay_pkg::addr_t      graph_base,
  input  logic [`GLAY_NUM_REQ-1:0] req_valid,
  input  glay_pkg::req_op_t    req_op [0:`GLAY_NUM_REQ-1],
  input  glay_pkg::addr_t      req_offset [0:`GLAY_NUM_REQ-1],
  input  glay_pkg::data_t      req_wdata [0:`GLAY_NUM_REQ-1],
  output logic [`GLAY_NUM_REQ-1:0] req_ready,
  output logic                 queue_empty,
  output logic                 mem_req_valid,
  output glay_pkg::req_op_t    mem_req_op,
  output glay_pkg::addr_t      mem_req_addr,
  output glay_pkg::data_t      mem_req_wdata,
  input  logic                 mem_req_ready
);

  localparam int IDX_W = $clog2(`GLAY_NUM_REQ);

  logic [`GLAY_NUM_REQ-1:0] grant;
  logic [IDX_W-1:0]         grant_idx;
  logic [IDX_W-1:0]         last_grant;
  logic                     push;
  logic                     pop;
  logic                     fifo_full;
  logic                     fifo_empty;

  // --------------------
  // Round-robin grant
  // --------------------
  // Search starts one past the last winner
  always_comb begin
    int   idx;
    logic hit;
    grant     = '0;
    grant_idx = '0;
    hit       = 1'b0;
    for (int k = 1; k <= `GLAY_NUM_REQ; k++) begin
      idx = (int'(last_grant) + k) % `GLAY_NUM_REQ;
      if (!hit && req_valid[idx]) begin
        hit        = 1'b1;
        grant[idx] = 1'b1;
        grant_idx  = IDX_W'(idx);
      end
    end
  end

  // Ready only for the winner, and only with room in the queue
  assign req_ready = (running && !fifo_full) ? grant : '0;
  assign push      = |(req_valid & req_ready);

  // Last winner moves only on a real transfer
  // Reset points at the top port so port 0 wins first
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      last_grant <= IDX_W'(`GLAY_NUM_REQ - 1);
    end else if (push) begin
      last_grant <= grant_idx;
    end
  end

  // --------------------
  // Request queue
  // --------------------
  glay_request_fifo u_request_fifo (
    .ap_clk       (ap_clk),
    .m_axi_areset (m_axi_areset),
    .push         (push),
    .push_op      (req_op[grant_idx]),
    .push_addr    (graph_base + req_offset[grant_idx]),
    .push_wdata   (req_wdata[grant_idx]),
    .full         (fifo_full),
    .empty        (fifo_empty),
    .head_op      (mem_req_op),
    .head_addr    (mem_req_addr),
    .head_wdata   (mem_req_wdata),
    .pop          (pop)
  );

  // Memory side handshake on the queue head
  assign mem_req_valid = !fifo_empty;
  assign pop           = mem_req_valid && mem_req_ready;

  // Drained means nothing stored and nothing arriving this cycle
  assign queue_empty = fifo_empty && !push;

endmodule

// ==== logic/glay_done_timer.sv ====
// Result stage: run length timer
// Counts cycles while running, saturates at the run length, and pulses
// run_done once the count is reached and the request queue has drained

`include "glay_settings.svh"

module glay_done_timer (
  input  logic ap_clk,
  input  logic m_axi_areset,
  input  logic running,
  input  logic queue_empty,
  output logic run_done
);

  localparam int CNT_W = $clog2(`GLAY_RUN_CYCLES + 1);

  logic [CNT_W-1:0] count;
  logic             expired;

  assign expired = (count == CNT_W'(`GLAY_RUN_CYCLES));

  // --------------------
  // Cycle count
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      count    <= '0;
      run_done <= 1'b0;
    end else if (!running) begin
      // Cleared between runs
      count    <= '0;
      run_done <= 1'b0;
    end else begin
      if (!expired) begin
        count <= count + 1'b1;
      end
      // Single pulse; decode drops running right after it
      run_done <= expired && queue_empty && !run_done;
    end
  end

endmodule

// ==== logic/glay_control_decode.sv ====
// Decode stage: host control sequence and descriptor capture
// Walks idle, setup, run and done from ap_start, the descriptor strobe,
// run_done and ap_continue; holds the graph base for the whole run

module glay_control_decode (
  input  logic             ap_clk,
  input  logic             m_axi_areset,
  input  logic             ap_start,
  input  logic             ap_continue,
  input  logic             descriptor_valid,
  input  glay_pkg::addr_t  descriptor_base,
  input  logic             run_done,
  output logic             ap_ready,
  output logic             ap_done,
  output logic             ap_idle,
  output logic             running,
  output glay_pkg::addr_t  graph_base
);

  glay_pkg::ctrl_state_t state;

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      state    <= glay_pkg::CTRL_IDLE;
      ap_ready <= 1'b0;
      ap_done  <= 1'b0;
      ap_idle  <= 1'b1;
    end else begin
      // Ready is a single cycle pulse
      ap_ready <= 1'b0;
      case (state)
        glay_pkg::CTRL_IDLE: begin
          if (ap_start) begin
            state   <= glay_pkg::CTRL_SETUP;
            ap_idle <= 1'b0;
          end
        end
        glay_pkg::CTRL_SETUP: begin
          // Wait here for the descriptor
          if (descriptor_valid) begin
            state    <= glay_pkg::CTRL_RUN;
            ap_ready <= 1'b1;
          end
        end
        glay_pkg::CTRL_RUN: begin
          if (run_done) begin
            state   <= glay_pkg::CTRL_DONE;
            ap_done <= 1'b1;
          end
        end
        glay_pkg::CTRL_DONE: begin
          // Done held until the host acknowledges
          if (ap_continue) begin
            state   <= glay_pkg::CTRL_IDLE;
            ap_done <= 1'b0;
            ap_idle <= 1'b1;
          end
        end
        default: begin
          state <= glay_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

  // --------------------
  // Descriptor capture
  // --------------------
  // Only a strobe seen in setup loads the base
  always_ff @(posedge ap_clk) begin
    if ((state == glay_pkg::CTRL_SETUP) && descriptor_valid) begin
      graph_base <= descriptor_base;
    end
  end

  // Run level for execute and result
  // Dropped in the run_done cycle so no request slips in behind the final drain
  assign running = (state == glay_pkg::CTRL_RUN) && !run_done;

endmodule

// ==== logic/glay_kernel_cu.sv ====
// Top of the graph kernel compute unit
// Decode drives the host handshake and base address, execute merges the
// requesters onto the memory port, result times the run

`include "glay_settings.svh"

module glay_kernel_cu (
  input  logic                 ap_clk,
  input  logic                 m_axi_areset,
  // Host control
  input  logic                 ap_start,
  input  logic                 ap_continue,
  output logic                 ap_ready,
  output logic                 ap_done,
  output logic                 ap_idle,
  // Descriptor
  input  logic                 descriptor_valid,
  input  glay_pkg::addr_t      descriptor_base,
  // Requesters
  input  logic [`GLAY_NUM_REQ-1:0] req_valid,
  input  glay_pkg::req_op_t    req_op [0:`GLAY_NUM_REQ-1],
  input  glay_pkg::addr_t      req_offset [0:`GLAY_NUM_REQ-1],
  input  glay_pkg::data_t      req_wdata [0:`GLAY_NUM_REQ-1],
  output logic [`GLAY_NUM_REQ-1:0] req_ready,
  // Memory port
  output logic                 mem_req_valid,
  output glay_pkg::req_op_t    mem_req_op,
  output glay_pkg::addr_t      mem_req_addr,
  output glay_pkg::data_t      mem_req_wdata,
  input  logic                 mem_req_ready
);

  logic            running;
  logic            queue_empty;
  logic            run_done;
  glay_pkg::addr_t graph_base;

  // --------------------
  // Decode
  // --------------------
  glay_control_decode u_control_decode (
    .ap_clk           (ap_clk),
    .m_axi_areset     (m_axi_areset),
    .ap_start         (ap_start),
    .ap_continue      (ap_continue),
    .descriptor_valid (descriptor_valid),
    .descriptor_base  (descriptor_base),
    .run_done         (run_done),
    .ap_ready         (ap_ready),
    .ap_done          (ap_done),
    .ap_idle          (ap_idle),
    .running          (running),
    .graph_base       (graph_base)
  );

  // --------------------
  // Execute
  // --------------------
  glay_request_arbiter u_request_arbiter (
    .ap_clk        (ap_clk),
    .m_axi_areset  (m_axi_areset),
    .running       (running),
    .graph_base    (graph_base),
    .req_valid     (req_valid),
    .req_op        (req_op),
    .req_offset    (req_offset),
    .req_wdata     (req_wdata),
    .req_ready     (req_ready),
    .queue_empty   (queue_empty),
    .mem_req_valid (mem_req_valid),
    .mem_req_op    (mem_req_op),
    .mem_req_addr  (mem_req_addr),
    .mem_req_wdata (mem_req_wdata),
    .mem_req_ready (mem_req_ready)
  );

  // --------------------
  // Result
  // --------------------
  glay_done_timer u_done_timer (
    .ap_clk       (ap_clk),
    .m_axi_areset (m_axi_areset),
    .running      (running),
    .queue_empty  (queue_empty),
    .run_done     (run_done)
  );

endmodule

// ==== testbench/glay_kernel_cu_props.sv ====
// Concurrent checks on the compute unit top level
// Bound into glay_kernel_cu; covers the host pulse and the request handshakes

`include "glay_settings.svh"

module glay_kernel_cu_props (
  input logic                     ap_clk,
  input logic                     m_axi_areset,
  input logic                     ap_ready,
  input logic                     ap_done,
  input logic                     ap_idle,
  input logic [`GLAY_NUM_REQ-1:0] req_ready,
  input logic                     mem_req_valid,
  input logic                     mem_req_ready
);

  // Run window as the host sees it
  // Opens with the ready pulse, closes once done is seen
  logic in_run;

  always_ff @(posedge ap_clk) begin
    if (m_axi_areset) begin
      in_run <= 1'b0;
    end else if (ap_ready) begin
      in_run <= 1'b1;
    end else if (ap_done) begin
      in_run <= 1'b0;
    end
  end

  // Ready lasts one cycle only
  ready_pulse: assert property (@(posedge ap_clk) disable iff (m_axi_areset)
    ap_ready |=> !ap_ready)
    else $error("ap_ready high for more than one cycle");

  // A queued request stays offered until memory takes it
  mem_valid_hold: assert property (@(posedge ap_clk) disable iff (m_axi_areset)
    (mem_req_valid && !mem_req_ready) |=> mem_req_valid)
    else $error("mem_req_valid dropped without a transfer");

  // Requesters only accepted during a run
  ready_in_run: assert property (@(posedge ap_clk) disable iff (m_axi_areset)
    (req_ready != '0) |-> ((ap_ready || in_run) && !ap_done))
    else $error("req_ready high outside the run state");

  done_not_idle: assert property (@(posedge ap_clk) disable iff (m_axi_areset)
    !(ap_done && ap_idle))
    else $error("ap_done and ap_idle high together");

endmodule

bind glay_kernel_cu glay_kernel_cu_props u_props (
  .ap_clk        (ap_clk),
  .m_axi_areset  (m_axi_areset),
  .ap_ready      (ap_ready),
  .ap_done       (ap_done),
  .ap_idle       (ap_idle),
  .req_ready     (req_ready),
  .mem_req_valid (mem_req_valid),
  .mem_req_ready (mem_req_ready)
);

// ==== testbench/glay_kernel_cu_tb.sv ====
// Testbench for the graph kernel compute unit
// Reads tests from the golden file, plays two requesters against a memory
// model with random stalls, and checks the host sequence and every request

`include "glay_settings.svh"

module glay_kernel_cu_tb;

  localparam int MAX_TESTS = 16;
  localparam int MAX_REQS  = 64;
  localparam int WAIT_MAX  = 4000;

  logic                     ap_clk;
  logic                     m_axi_areset;
  logic                     ap_start;
  logic                     ap_continue;
  logic                     ap_ready;
  logic                     ap_done;
  logic                     ap_idle;
  logic                     descriptor_valid;
  glay_pkg::addr_t          descriptor_base;
  logic [`GLAY_NUM_REQ-1:0] req_valid = '0;
  glay_pkg::req_op_t        req_op [0:`GLAY_NUM_REQ-1] = '{default: glay_pkg::OP_READ};
  glay_pkg::addr_t          req_offset [0:`GLAY_NUM_REQ-1] = '{default: '0};
  glay_pkg::data_t          req_wdata [0:`GLAY_NUM_REQ-1] = '{default: '0};
  logic [`GLAY_NUM_REQ-1:0] req_ready;
  logic                     mem_req_valid;
  glay_pkg::req_op_t        mem_req_op;
  glay_pkg::addr_t          mem_req_addr;
  glay_pkg::data_t          mem_req_wdata;
  logic                     mem_req_ready = 1'b0;

  // --------------------
  // Golden tables
  // --------------------
  glay_pkg::addr_t t_stray [MAX_TESTS];
  glay_pkg::addr_t t_base [MAX_TESTS];
  int              t_stall [MAX_TESTS];
  int              t_alt [MAX_TESTS];
  int              t_first [MAX_TESTS];
  int              t_num [MAX_TESTS];
  int              r_port [MAX_REQS];
  int              r_op [MAX_REQS];
  glay_pkg::addr_t r_off [MAX_REQS];
  glay_pkg::data_t r_wdata [MAX_REQS];
  glay_pkg::addr_t r_exp [MAX_REQS];
  int              num_tests = 0;
  int              num_reqs = 0;

  // Per port request lists for the running test
  int p_list [`GLAY_NUM_REQ][MAX_REQS];
  int p_cnt [`GLAY_NUM_REQ];
  int p_pos [`GLAY_NUM_REQ];
  // Accepted requests in queue order
  int accq [$];

  logic offering = 1'b0;
  int   cur_stall = 0;
  int   cur_alt = 0;
  int   cur_num = 0;
  int   occ = 0;
  int   delivered = 0;
  int   ready_cnt = 0;
  int   ready_cycle = 0;
  int   cycle = 0;
  int   done_seen = 0;
  int   exp_port = 0;
  int   full_hits = 0;
  int   errors = 0;

  glay_kernel_cu DUT (.*);

  initial ap_clk = 1'b0;
  always #5 ap_clk = ~ap_clk;

  task automatic flag_error(input string msg);
    $display("ERROR t=%0t %s", $time, msg);
    errors++;
  endtask

  task automatic abort_run(input string why);
    $display("Run stopped: %s", why);
    $display("** FAIL **");
    $finish;
  endtask

  // Fills the tables; R lines attach to the last T line
  task automatic load_golden();
    int              fd;
    int              n;
    string           line;
    int              a;
    int              b;
    glay_pkg::addr_t x;
    glay_pkg::addr_t y;
    glay_pkg::data_t w;
    fd = $fopen("testbench/glay_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open testbench/glay_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) == "T") begin
          n = $sscanf(line, "T %h %h %d %d", x, y, a, b);
          t_stray[num_tests] = x;
          t_base[num_tests]  = y;
          t_stall[num_tests] = a;
          t_alt[num_tests]   = b;
          t_first[num_tests] = num_reqs;
          t_num[num_tests]   = 0;
          num_tests++;
        end else if (n > 0 && line.getc(0) == "R") begin
          n = $sscanf(line, "R %d %d %h %h %h", a, b, x, w, y);
          r_port[num_reqs]  = a;
          r_op[num_reqs]    = b;
          r_off[num_reqs]   = x;
          r_wdata[num_reqs] = w;
          r_exp[num_reqs]   = y;
          t_num[num_tests-1]++;
          num_reqs++;
        end
      end
      $fclose(fd);
    end
  endtask

  // --------------------
  // Requesters and memory stalls
  // --------------------
  always @(negedge ap_clk) begin
    int k;
    for (int i = 0; i < `GLAY_NUM_REQ; i++) begin
      if (offering && (p_pos[i] < p_cnt[i])) begin
        k = p_list[i][p_pos[i]];
        req_valid[i]  <= 1'b1;
        req_op[i]     <= glay_pkg::req_op_t'(r_op[k]);
        req_offset[i] <= r_off[k];
        req_wdata[i]  <= r_wdata[k];
      end else begin
        req_valid[i] <= 1'b0;
      end
    end
    // Stall chance in percent
    mem_req_ready <= (($urandom % 100) >= cur_stall);
  end

  // --------------------
  // Monitor and scoreboard
  // --------------------
  always @(posedge ap_clk) begin
    int k;
    if (!m_axi_areset) begin
      cycle++;
      // Queue model says full, so nobody may be ready
      if (occ >= `GLAY_FIFO_DEPTH) begin
        full_hits++;
        assert (req_ready == '0) else flag_error("req_ready high while queue full");
      end
      if (mem_req_valid && mem_req_ready) begin
        assert (accq.size() != 0) else flag_error("memory request with none accepted");
        if (accq.size() != 0) begin
          k = accq.pop_front();
          assert (mem_req_op == glay_pkg::req_op_t'(r_op[k]))
            else flag_error($sformatf("req %0d op %0d", k, mem_req_op));
          assert (mem_req_addr == r_exp[k])
            else flag_error($sformatf("req %0d addr %h exp %h", k, mem_req_addr, r_exp[k]));
          assert (mem_req_wdata == r_wdata[k])
            else flag_error($sformatf("req %0d data %h exp %h", k, mem_req_wdata, r_wdata[k]));
          occ--;
          delivered++;
        end
      end
      for (int i = 0; i < `GLAY_NUM_REQ; i++) begin
        if (req_valid[i] && req_ready[i]) begin
          accq.push_back(p_list[i][p_pos[i]]);
          p_pos[i]++;
          occ++;
          if (cur_alt != 0) begin
            assert (i == exp_port) else flag_error($sformatf("port %0d won out of turn", i));
            exp_port = (i + 1) % `GLAY_NUM_REQ;
          end
        end
      end
      if (ap_ready) begin
        ready_cnt++;
        ready_cycle = cycle;
      end
      if (ap_done && done_seen == 0) begin
        done_seen = 1;
        assert (cycle - ready_cycle >= `GLAY_RUN_CYCLES)
          else flag_error($sformatf("done %0d cycles after ready", cycle - ready_cycle));
        assert (delivered == cur_num)
          else flag_error($sformatf("done with %0d of %0d delivered", delivered, cur_num));
      end
    end
  end

  task automatic run_test(input int t);
    int n;
    int err0;
    int pidx;
    err0 = errors;
    for (int i = 0; i < `GLAY_NUM_REQ; i++) begin
      p_cnt[i] = 0;
      p_pos[i] = 0;
    end
    for (int k = t_first[t]; k < t_first[t] + t_num[t]; k++) begin
      pidx = r_port[k];
      p_list[pidx][p_cnt[pidx]] = k;
      p_cnt[pidx]++;
    end
    cur_stall = t_stall[t];
    cur_alt   = t_alt[t];
    cur_num   = t_num[t];
    delivered = 0;
    ready_cnt = 0;
    done_seen = 0;
    exp_port  = 0;
    full_hits = 0;
    // Strobe while idle, ignored by decode
    if (t_stray[t] != '0) begin
      descriptor_valid <= 1'b1;
      descriptor_base  <= t_stray[t];
      @(negedge ap_clk);
      descriptor_valid <= 1'b0;
    end
    ap_start <= 1'b1;
    n = 0;
    while (ap_idle) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_MAX) abort_run("timeout waiting for ap_idle to fall");
    end
    ap_start         <= 1'b0;
    descriptor_valid <= 1'b1;
    descriptor_base  <= t_base[t];
    offering         <= 1'b1;
    @(negedge ap_clk);
    descriptor_valid <= 1'b0;
    descriptor_base  <= '0;
    n = 0;
    while (!ap_done) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_MAX) abort_run("timeout waiting for ap_done");
    end
    assert (ready_cnt == 1) else flag_error($sformatf("%0d ap_ready pulses", ready_cnt));
    assert (accq.size() == 0) else flag_error("accepted requests left undelivered");
    offering    <= 1'b0;
    ap_continue <= 1'b1;
    n = 0;
    while (!ap_idle) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_MAX) abort_run("timeout waiting for ap_idle after ap_continue");
    end
    ap_continue <= 1'b0;
    $display("test %0d: base %h, %0d requests, %0d full cycles, %0d errors",
             t, t_base[t], cur_num, full_hits, errors - err0);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    void'($urandom(32'h748b_a622));
    m_axi_areset     = 1'b1;
    ap_start         = 1'b0;
    ap_continue      = 1'b0;
    descriptor_valid = 1'b0;
    descriptor_base  = '0;
    load_golden();
    repeat (16) @(posedge ap_clk);
    @(negedge ap_clk);
    m_axi_areset <= 1'b0;
    @(negedge ap_clk);
    assert (ap_idle === 1'b1 && ap_done === 1'b0 && ap_ready === 1'b0
            && mem_req_valid === 1'b0) else flag_error("outputs wrong after reset");
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("tests %0d, requests %0d, errors %0d", num_tests, num_reqs, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== testbench/glay_golden.txt ====
# T stray_base base stall_pct alt_check (hex hex dec dec), stray_base 0 means none
# R port op offset wdata expected_addr (dec dec hex hex hex), belongs to the last T
T 00000000 10000000 0 1
R 0 1 00000000 a0000001 10000000
R 1 0 00000100 00000000 10000100
R 0 0 00000004 00000000 10000004
R 1 1 00000104 b0000002 10000104
R 0 1 00000008 a0000003 10000008
R 1 1 00000108 b0000004 10000108
T 00000000 20004000 0 0
R 1 0 00000010 00000000 20004010
R 1 1 00000020 5a5a0001 20004020
R 1 1 00000030 5a5a0002 20004030
R 1 0 00000040 00000000 20004040
T 00000000 3fff0000 60 0
R 0 1 00000000 11110000 3fff0000
R 0 1 00000004 11110001 3fff0004
R 1 0 00002000 00000000 3fff2000
R 0 0 00000008 00000000 3fff0008
R 1 1 00002004 22220001 3fff2004
R 1 1 00002008 22220002 3fff2008
R 0 1 0000000c 11110002 3fff000c
R 1 0 0000200c 00000000 3fff200c
R 0 1 00000010 11110003 3fff0010
R 1 1 00010010 22220003 40000010
T dead0000 40000000 30 0
R 0 0 00000040 00000000 40000040
R 1 1 00000080 33330001 40000080
R 0 1 000000c0 33330002 400000c0

// ==== sim.f ====
+incdir+include
logic/glay_pkg.sv
logic/glay_request_fifo.sv
logic/glay_request_arbiter.sv
logic/glay_done_timer.sv
logic/glay_control_decode.sv
logic/glay_kernel_cu.sv
testbench/glay_kernel_cu_props.sv
testbench/glay_kernel_cu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run the testbench, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module glay_kernel_cu_tb -f sim.f -o sim_glay
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_glay > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$log"; then
  echo "Simulation passed"
  exit 0
fi
echo "Simulation failed"
exit 1
